// ==== rtl/dmni_consts.svh ====
`ifndef DMNI_CONSTS_SVH
`define DMNI_CONSTS_SVH

// Flit width, also the memory word width
`define DMNI_FLIT_W 32

// Byte address increment per memory word
`define DMNI_WORD_STEP 4

// Cycles an engine keeps the memory port while the other waits
`define DMNI_SLICE_CYCLES 16

`endif

// ==== rtl/dmni_noc_pkg.sv ====
`include "dmni_consts.svh"

package dmni_noc_pkg;

    // One flit on the Hermes port
    typedef logic [`DMNI_FLIT_W-1:0] flit_t;

    // Receive engine, one-hot
    typedef enum logic [2:0] {
        RCV_IDLE = 3'b001,
        RCV_WAIT = 3'b010,
        RCV_DATA = 3'b100
    } rcv_state_t;

    // Send engine, one-hot
    typedef enum logic [2:0] {
        SND_IDLE = 3'b001,
        SND_DATA = 3'b010,
        SND_LAST = 3'b100
    } snd_state_t;

endpackage

// ==== rtl/dmni_mem_pkg.sv ====
`include "dmni_consts.svh"

package dmni_mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [`DMNI_FLIT_W-1:0] word_t;

    // Size in words, not bytes
    typedef logic [31:0] size_t;

    // Owner of the memory port
    typedef enum logic [1:0] {
        GRANT_NONE    = 2'd0,
        GRANT_SEND    = 2'd1,
        GRANT_RECEIVE = 2'd2
    } grant_t;

endpackage

// ==== rtl/dmni_mem_if.sv ====
`include "dmni_consts.svh"

interface dmni_mem_if;

    // Engine side request
    logic                    pend;
    logic                    en;
    logic                    we;
    logic [31:0]             addr;
    logic [`DMNI_FLIT_W-1:0] wdata;

    // Arbiter side answer
    logic [`DMNI_FLIT_W-1:0] rdata;
    logic                    grant;

    modport engine (
        output pend,
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  grant
    );

    modport arbiter (
        input  pend,
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output grant
    );

endinterface

// ==== rtl/dmni_receive.sv ====
`include "dmni_consts.svh"

module dmni_receive (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                noc_rx_i,
    input  logic                noc_eop_i,
    input  dmni_noc_pkg::flit_t noc_data_i,
    output logic                noc_credit_o,

    input  logic                st_rcv_i,
    input  dmni_mem_pkg::addr_t address_i,
    input  dmni_mem_pkg::size_t size_i,
    output dmni_mem_pkg::size_t received_cnt_o,
    output logic                receive_active_o,
    output logic                receive_available_o,

    dmni_mem_if.engine          mem
);

    dmni_noc_pkg::rcv_state_t state_q;
    dmni_noc_pkg::rcv_state_t state_d;
    dmni_mem_pkg::addr_t      addr_q;
    dmni_mem_pkg::size_t      size_q;
    logic                     consume;

    assign receive_active_o    = (state_q == dmni_noc_pkg::RCV_DATA);
    assign receive_available_o = (state_q == dmni_noc_pkg::RCV_WAIT);

    // Credit only while writing and owning the memory
    assign noc_credit_o = receive_active_o && mem.grant;
    assign consume      = noc_rx_i && noc_credit_o;

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            dmni_noc_pkg::RCV_IDLE: begin
                // Head flit waiting at the input
                if (noc_rx_i)
                    state_d = dmni_noc_pkg::RCV_WAIT;
            end
            dmni_noc_pkg::RCV_WAIT: begin
                if (st_rcv_i)
                    state_d = dmni_noc_pkg::RCV_DATA;
            end
            dmni_noc_pkg::RCV_DATA: begin
                if (consume && noc_eop_i)
                    state_d = dmni_noc_pkg::RCV_IDLE;
                else if (consume && size_q == 32'd1)
                    state_d = dmni_noc_pkg::RCV_WAIT;
            end
            default: state_d = dmni_noc_pkg::RCV_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            state_q <= dmni_noc_pkg::RCV_IDLE;
        else
            state_q <= state_d;
    end

    // Target address and remaining words
    always_ff @(posedge clk_i) begin
        if (receive_available_o && st_rcv_i) begin
            addr_q <= address_i;
            size_q <= size_i;
        end else if (consume) begin
            addr_q <= addr_q + 32'(`DMNI_WORD_STEP);
            size_q <= size_q - 32'd1;
        end
    end

    // Received bytes since the last start pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            received_cnt_o <= '0;
        else if (st_rcv_i)
            received_cnt_o <= '0;
        else if (consume)
            received_cnt_o <= received_cnt_o + 32'(`DMNI_FLIT_W / 8);
    end

    // Write request straight from the NoC input
    assign mem.pend  = receive_active_o;
    assign mem.en    = receive_active_o && noc_rx_i;
    assign mem.we    = 1'b1;
    assign mem.addr  = addr_q;
    assign mem.wdata = noc_data_i;

    // Grant answers a request from the cycle before
    a_credit_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_credit_o |-> $past(mem.pend));

endmodule

// ==== rtl/dmni_send.sv ====
`include "dmni_consts.svh"

module dmni_send (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                noc_ack_i,
    output logic                noc_tx_o,
    output logic                noc_eop_o,
    output dmni_noc_pkg::flit_t noc_data_o,

    input  logic                st_snd_i,
    input  dmni_mem_pkg::addr_t address_i,
    input  dmni_mem_pkg::size_t size_i,
    output logic                send_active_o,

    dmni_mem_if.engine          mem
);

    dmni_noc_pkg::snd_state_t state_q;
    dmni_noc_pkg::snd_state_t state_d;
    dmni_mem_pkg::addr_t      addr_q;
    dmni_mem_pkg::size_t      size_q;
    logic                     accept;

    assign send_active_o = (state_q != dmni_noc_pkg::SND_IDLE);
    assign noc_tx_o      = send_active_o && mem.grant;
    assign noc_eop_o     = noc_tx_o && (state_q == dmni_noc_pkg::SND_LAST);

    // Read data is combinational, the flit follows the address
    assign noc_data_o = mem.rdata;
    assign accept     = noc_tx_o && noc_ack_i;

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            dmni_noc_pkg::SND_IDLE: begin
                if (st_snd_i && size_i != '0)
                    state_d = (size_i == 32'd1) ? dmni_noc_pkg::SND_LAST
                                                : dmni_noc_pkg::SND_DATA;
            end
            dmni_noc_pkg::SND_DATA: begin
                // Two words left before this accept
                if (accept && size_q == 32'd2)
                    state_d = dmni_noc_pkg::SND_LAST;
            end
            dmni_noc_pkg::SND_LAST: begin
                if (accept)
                    state_d = dmni_noc_pkg::SND_IDLE;
            end
            default: state_d = dmni_noc_pkg::SND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            state_q <= dmni_noc_pkg::SND_IDLE;
        else
            state_q <= state_d;
    end

    // Without ack both counters hold
    always_ff @(posedge clk_i) begin
        if (!send_active_o && st_snd_i) begin
            addr_q <= address_i;
            size_q <= size_i;
        end else if (accept) begin
            addr_q <= addr_q + 32'(`DMNI_WORD_STEP);
            size_q <= size_q - 32'd1;
        end
    end

    // Read-only requester
    assign mem.pend  = send_active_o;
    assign mem.en    = send_active_o;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    // eop marks the word accepted with one left
    a_eop_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_eop_o |-> noc_tx_o && size_q == 32'd1);

    a_tx_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_o |-> mem.grant && $past(mem.pend));

endmodule

// ==== rtl/dmni_mem_arbiter.sv ====
`include "dmni_consts.svh"

module dmni_mem_arbiter (
    input  logic                clk_i,
    input  logic                rst_ni,

    dmni_mem_if.arbiter         snd,
    dmni_mem_if.arbiter         rcv,

    output logic                mem_en_o,
    output logic [3:0]          mem_we_o,
    output dmni_mem_pkg::addr_t mem_addr_o,
    output dmni_mem_pkg::word_t mem_data_o,
    input  dmni_mem_pkg::word_t mem_data_i
);

    localparam int unsigned SLICE_W = $clog2(`DMNI_SLICE_CYCLES);

    dmni_mem_pkg::grant_t grant_q;
    dmni_mem_pkg::grant_t grant_d;
    logic [SLICE_W-1:0]   slice_q;
    logic                 slice_done;
    logic                 sel_en;
    logic                 sel_we;

    assign slice_done = (slice_q == SLICE_W'(`DMNI_SLICE_CYCLES - 1));

    //////////////////////////////////////////////////////////////////////
    // Round-robin with time slice
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            dmni_mem_pkg::GRANT_SEND: begin
                if (!snd.pend || (slice_done && rcv.pend))
                    grant_d = rcv.pend ? dmni_mem_pkg::GRANT_RECEIVE
                                       : dmni_mem_pkg::GRANT_NONE;
            end
            dmni_mem_pkg::GRANT_RECEIVE: begin
                if (!rcv.pend || (slice_done && snd.pend))
                    grant_d = snd.pend ? dmni_mem_pkg::GRANT_SEND
                                       : dmni_mem_pkg::GRANT_NONE;
            end
            default: begin
                // Receive first on an idle port so the NoC input drains
                if (rcv.pend)
                    grant_d = dmni_mem_pkg::GRANT_RECEIVE;
                else if (snd.pend)
                    grant_d = dmni_mem_pkg::GRANT_SEND;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            grant_q <= dmni_mem_pkg::GRANT_NONE;
            slice_q <= '0;
        end else begin
            grant_q <= grant_d;
            // New slice on every handover or expiry
            if (grant_d != grant_q || slice_done)
                slice_q <= '0;
            else if (grant_q != dmni_mem_pkg::GRANT_NONE)
                slice_q <= slice_q + 1'b1;
        end
    end

    assign snd.grant = (grant_q == dmni_mem_pkg::GRANT_SEND);
    assign rcv.grant = (grant_q == dmni_mem_pkg::GRANT_RECEIVE);
    assign snd.rdata = mem_data_i;
    assign rcv.rdata = mem_data_i;

    //////////////////////////////////////////////////////////////////////
    // Memory port mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (grant_q)
            dmni_mem_pkg::GRANT_SEND: begin
                sel_en     = snd.en;
                sel_we     = snd.we;
                mem_addr_o = snd.addr;
                mem_data_o = snd.wdata;
            end
            dmni_mem_pkg::GRANT_RECEIVE: begin
                sel_en     = rcv.en;
                sel_we     = rcv.we;
                mem_addr_o = rcv.addr;
                mem_data_o = rcv.wdata;
            end
            default: begin
                sel_en     = 1'b0;
                sel_we     = 1'b0;
                mem_addr_o = '0;
                mem_data_o = '0;
            end
        endcase
    end

    assign mem_en_o = sel_en;
    assign mem_we_o = {4{sel_en && sel_we}};

    // A grant only goes to an engine that was pending at the edge before
    a_grant_requested: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (snd.grant -> $past(snd.pend)) && (rcv.grant -> $past(rcv.pend)));

    // Only the receive engine ever writes
    a_we_receive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_we_o != '0 |-> grant_q == dmni_mem_pkg::GRANT_RECEIVE);

endmodule

// ==== rtl/dmni_dma.sv ====
`include "dmni_consts.svh"

module dmni_dma (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // NoC input
    input  logic                    noc_rx_i,
    input  logic                    noc_eop_i,
    input  logic [`DMNI_FLIT_W-1:0] noc_data_i,
    output logic                    noc_credit_o,

    // NoC output
    output logic                    noc_tx_o,
    output logic                    noc_eop_o,
    input  logic                    noc_ack_i,
    output logic [`DMNI_FLIT_W-1:0] noc_data_o,

    // Memory port
    output logic                    mem_en_o,
    output logic [3:0]              mem_we_o,
    output logic [31:0]             mem_addr_o,
    input  logic [`DMNI_FLIT_W-1:0] mem_data_i,
    output logic [`DMNI_FLIT_W-1:0] mem_data_o,

    // Software configuration, address and size shared by both engines
    input  logic                    st_rcv_i,
    input  logic                    st_snd_i,
    input  logic [31:0]             address_i,
    input  logic [31:0]             size_i,
    output logic [31:0]             received_cnt_o,
    output logic                    send_active_o,
    output logic                    receive_active_o,
    output logic                    receive_available_o
);

    dmni_mem_if rcv_mem ();
    dmni_mem_if snd_mem ();

    dmni_receive u_receive (
        .clk_i, .rst_ni,
        .noc_rx_i, .noc_eop_i, .noc_data_i, .noc_credit_o,
        .st_rcv_i, .address_i, .size_i,
        .received_cnt_o, .receive_active_o, .receive_available_o,
        .mem (rcv_mem.engine)
    );

    dmni_send u_send (
        .clk_i, .rst_ni,
        .noc_ack_i, .noc_tx_o, .noc_eop_o, .noc_data_o,
        .st_snd_i, .address_i, .size_i,
        .send_active_o,
        .mem (snd_mem.engine)
    );

    dmni_mem_arbiter u_arbiter (
        .clk_i, .rst_ni,
        .snd (snd_mem.arbiter),
        .rcv (rcv_mem.arbiter),
        .mem_en_o, .mem_we_o, .mem_addr_o, .mem_data_o, .mem_data_i
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic clk_o,
    output logic rst_no
);

    // Period of 4 time units
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held for 8 cycles, released away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// ==== bench/tb_dmni.sv ====
module tb_dmni;

    logic        clk_i;
    logic        rst_ni;
    logic        noc_rx_i;
    logic        noc_eop_i;
    logic [31:0] noc_data_i;
    logic        noc_credit_o;
    logic        noc_tx_o;
    logic        noc_eop_o;
    logic        noc_ack_i;
    logic [31:0] noc_data_o;
    logic        mem_en_o;
    logic [3:0]  mem_we_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_data_i;
    logic [31:0] mem_data_o;
    logic        st_rcv_i;
    logic        st_snd_i;
    logic [31:0] address_i;
    logic [31:0] size_i;
    logic [31:0] received_cnt_o;
    logic        send_active_o;
    logic        receive_active_o;
    logic        receive_available_o;

    logic [31:0] stim [0:255];
    logic [31:0] mem_model [logic [31:0]];
    logic [31:0] ref_mem [logic [31:0]];
    logic [15:0] lfsr = 16'd50336;
    int          limit = 0;
    int          cycle_cnt = 0;

    tb_clock u_clock (.clk_o (clk_i), .rst_no (rst_ni));

    dmni_dma u_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h5A5A_C3C3;
    endfunction

    // Combinational read with the fill pattern for unwritten words
    always_comb begin
        if (mem_model.exists(mem_addr_o))
            mem_data_i = mem_model[mem_addr_o];
        else
            mem_data_i = fill_word(mem_addr_o);
    end

    always @(posedge clk_i) begin
        if (mem_en_o && mem_we_o == 4'hf)
            mem_model[mem_addr_o] = mem_data_o;
    end

    // Word the send engine must deliver according to the preload records
    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        if (ref_mem.exists(addr))
            return ref_mem[addr];
        return fill_word(addr);
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Error handling and timeout
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("[FAIL] %0t: %s", $time, what);
            abort_run();
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit != 0 && cycle_cnt > limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    // Flits and send words over all records for the timeout
    function automatic int count_flits();
        int pos;
        int op;
        int total;
        pos = 0;
        total = 0;
        op = int'(stim[0]);
        while (op != 0) begin
            case (op)
                1: pos += 3 + int'(stim[pos+2]);
                2: begin
                    total += int'(stim[pos+5]);
                    pos += 6 + int'(stim[pos+5]);
                end
                3: begin
                    total += int'(stim[pos+2]);
                    pos += 3;
                end
                default: begin
                    total += int'(stim[pos+5]) + int'(stim[pos+7+int'(stim[pos+5])]);
                    pos += 8 + int'(stim[pos+5]);
                end
            endcase
            op = int'(stim[pos]);
        end
        return total;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Job driver with one pass per falling edge
    //////////////////////////////////////////////////////////////////////

    // rpos and spos point at the receive and send fields or are -1 when absent
    task automatic run_jobs(input int rpos, input int spos, input logic rnd);
        int          r_phase;
        int          r_idx;
        int          r_n;
        int          r_left;
        int          s_phase;
        int          s_left;
        logic [31:0] r_addr;
        logic [31:0] s_addr;
        logic        r_go;
        r_phase = 0;
        r_idx = 0;
        r_n = 0;
        r_left = 0;
        r_addr = '0;
        r_go = 1'b0;
        s_phase = 0;
        s_left = 0;
        s_addr = '0;
        if (rpos >= 0) begin
            r_phase = 1;
            r_n = int'(stim[rpos+4]);
        end
        if (spos >= 0) begin
            s_phase = 1;
            s_addr = stim[spos];
            s_left = int'(stim[spos+1]);
        end
        while (r_phase != 0 || s_phase != 0) begin
            @(negedge clk_i);
            check(!(noc_tx_o && mem_we_o != '0), "memory write while a flit is sent");
            // Flit consumed at the last rising edge
            if (r_go) begin
                check(mem_model.exists(r_addr) && mem_model[r_addr] == stim[rpos+5+r_idx],
                      "received flit not stored at its address");
                r_idx++;
                r_addr += 32'd4;
                r_left--;
                noc_rx_i = 1'b0;
                if (r_idx == r_n) begin
                    check(!receive_active_o, "receive_active_o still high after eop");
                    check(received_cnt_o == stim[rpos+3], "wrong received byte count");
                    r_phase = 0;
                end else if (r_left == 0) begin
                    check(receive_available_o, "no receive_available_o after size ran out");
                    r_phase = 1;
                end
            end
            if (s_phase == 3) begin
                check(!send_active_o, "send_active_o still high after the last flit");
                s_phase = 0;
            end
            if (s_phase == 4) begin
                check(send_active_o, "send_active_o not high after the start pulse");
                s_phase = 2;
            end
            // Start pulses share the address and size bus
            st_rcv_i = 1'b0;
            st_snd_i = 1'b0;
            if (r_phase == 1 && receive_available_o) begin
                st_rcv_i = 1'b1;
                if (r_idx == 0) begin
                    address_i = stim[rpos];
                    size_i = stim[rpos+1];
                end else begin
                    address_i = stim[rpos+2];
                    size_i = r_n - r_idx;
                end
                r_addr = address_i;
                r_left = int'(size_i);
                r_phase = 2;
            end else if (s_phase == 1) begin
                st_snd_i = 1'b1;
                address_i = s_addr;
                size_i = s_left;
                s_phase = 4;
            end
            // Source holds a presented flit until credit
            if (r_phase != 0 && !noc_rx_i) begin
                noc_rx_i = rnd ? next_bit() : 1'b1;
                noc_data_i = stim[rpos+5+r_idx];
                noc_eop_i = (r_idx == r_n - 1);
            end
            r_go = noc_rx_i && noc_credit_o;
            noc_ack_i = 1'b0;
            if (s_phase == 2) begin
                noc_ack_i = rnd ? next_bit() : 1'b1;
                if (noc_tx_o && noc_ack_i) begin
                    check(noc_data_o == expect_word(s_addr), "sent flit differs from memory");
                    check(noc_eop_o == (s_left == 1), "eop not on the last flit only");
                    s_addr += 32'd4;
                    s_left--;
                    if (s_left == 0)
                        s_phase = 3;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int pos;
        int op;
        int n;
        noc_rx_i = 1'b0;
        noc_eop_i = 1'b0;
        noc_data_i = '0;
        noc_ack_i = 1'b0;
        st_rcv_i = 1'b0;
        st_snd_i = 1'b0;
        address_i = '0;
        size_i = '0;
        $readmemh("bench/dmni_stimulus.txt", stim);
        limit = 40 * count_flits() + 200;

        wait (rst_ni == 1'b1);
        @(negedge clk_i);
        check(!noc_tx_o && !noc_eop_o && !noc_credit_o, "NoC outputs not low after reset");
        check(!mem_en_o && mem_we_o == '0, "memory strobes not low after reset");
        check(!send_active_o && !receive_active_o && !receive_available_o,
              "status flags not low after reset");

        pos = 0;
        op = int'(stim[0]);
        while (op != 0) begin
            case (op)
                1: begin
                    n = int'(stim[pos+2]);
                    for (int i = 0; i < n; i++) begin
                        mem_model[stim[pos+1] + 32'(4 * i)] = stim[pos+3+i];
                        ref_mem[stim[pos+1] + 32'(4 * i)] = stim[pos+3+i];
                    end
                    pos += 3 + n;
                end
                2: begin
                    run_jobs(pos + 1, -1, 1'b0);
                    pos += 6 + int'(stim[pos+5]);
                end
                3: begin
                    run_jobs(-1, pos + 1, 1'b0);
                    pos += 3;
                end
                default: begin
                    n = int'(stim[pos+5]);
                    run_jobs(pos + 1, pos + 6 + n, 1'b1);
                    pos += 8 + n;
                end
            endcase
            op = int'(stim[pos]);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/dmni_noc_pkg.sv
rtl/dmni_mem_pkg.sv
rtl/dmni_mem_if.sv
rtl/dmni_receive.sv
rtl/dmni_send.sv
rtl/dmni_mem_arbiter.sv
rtl/dmni_dma.sv
bench/tb_clock.sv
bench/tb_dmni.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the DMNI testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_dmni

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/Vtb_dmni

// ==== bench/dmni_stimulus.txt ====
// Hex records: opcode then fields, 0 ends the list. 1 preload: addr count words
// 2 receive: addr1 size1 addr2 bytes nflits flits (eop on last), 3 send: addr size
// 4 receive and send with random back-pressure: receive fields then send fields

// Preload six words at 0x100
1 00000100 6
11110000 22220001 33330002 44440003 55550004 66660005

// Full receive, four flits header first
2 00000400 8 00000000 10 4
00020001 00000003 cafe0001 cafe0002

// Split receive, two words at 0x500 then three at 0x600
2 00000500 2 00000600 c 5
00020002 00000004 beef0001 beef0002 beef0003

// Send six words, then a single word
3 00000100 6
3 00000114 1

// Concurrent receive and send
4 00000700 10 00000000 18 6
00020003 00000005 d00d0001 d00d0002 d00d0003 d00d0004
00000100 6

0
